//--- src/dz_pkg.sv
package dz_pkg;

    // pattern number from the game logic
    typedef logic [3:0] pat_t;

    // row index into the matrix, 0 is the top row
    typedef logic [2:0] row_idx_t;

    // one row of column bits, 1 lights the led
    typedef logic [7:0] cols_t;

    // row select, active low
    typedef logic [7:0] rows_t;

    // number of rows in the matrix
    parameter int ROWS = 8;

    // patterns with a red bitmap of their own and no green
    parameter pat_t PAT_RED_A = 4'd8;
    parameter pat_t PAT_RED_B = 4'd11;

    // never shown in red
    parameter pat_t PAT_GREEN_ONLY = 4'd10;

endpackage

//--- src/tick_gen.sv
`timescale 1ns/1ps

module tick_gen #(
    parameter int SCAN_DIV = 50000
) (
    input  logic clk,
    input  logic st,
    output logic scan_tick
);

    localparam int CW = (SCAN_DIV > 2) ? $clog2(SCAN_DIV) : 1;

    logic [CW-1:0] cnt;

    // down counter, one strobe per SCAN_DIV clocks
    always_ff @(posedge clk or negedge st)
    begin
        if (!st)
        begin
            cnt       <= CW'(SCAN_DIV - 1);
            scan_tick <= 1'b0;
        end
        else
        begin
            scan_tick <= (cnt == '0);
            if (cnt == '0)
                cnt <= CW'(SCAN_DIV - 1);  // reload
            else
                cnt <= cnt - 1'b1;
        end
    end

endmodule

//--- src/pattern_rom.sv
`timescale 1ns/1ps

module pattern_rom (
    input  dz_pkg::pat_t     pat,
    input  dz_pkg::row_idx_t row_idx,
    output dz_pkg::cols_t    green,
    output dz_pkg::cols_t    red
);

    // green plane
    always_comb
    begin
        green = '0;
        case (pat)
            4'd0:
            begin
                case (row_idx)
                    3'd2, 3'd5: green = 8'b0001_1000;
                    3'd3, 3'd4: green = 8'b0011_1100;
                    default:    green = '0;
                endcase
            end
            4'd1:
            begin
                case (row_idx)
                    3'd2, 3'd5: green = 8'b0011_1000;
                    3'd3, 3'd4: green = 8'b0111_1100;
                    default:    green = '0;
                endcase
            end
            4'd2:
            begin
                case (row_idx)
                    3'd2, 3'd5: green = 8'b0011_1100;
                    3'd3, 3'd4: green = 8'b0111_1110;
                    default:    green = '0;
                endcase
            end
            4'd3:
            begin
                case (row_idx)
                    3'd1, 3'd6:             green = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: green = 8'b0111_1110;
                    default:                green = '0;
                endcase
            end
            4'd4:
            begin
                case (row_idx)
                    3'd0, 3'd7:             green = 8'b0011_1100;
                    3'd1, 3'd6:             green = 8'b0111_1110;
                    3'd2, 3'd3, 3'd4, 3'd5: green = 8'b1111_1111;
                    default:                green = '0;
                endcase
            end
            4'd5:
            begin
                green = 8'b1111_1111;  // full matrix
            end
            4'd6:
            begin
                case (row_idx)
                    3'd0:    green = 8'b1100_0011;
                    3'd1:    green = 8'b1110_0011;
                    3'd2:    green = 8'b1111_0001;
                    3'd3:    green = 8'b1110_0011;
                    3'd4:    green = 8'b1100_0111;
                    3'd5:    green = 8'b1110_0111;
                    3'd6:    green = 8'b1111_0111;
                    3'd7:    green = 8'b1111_1011;
                    default: green = '0;
                endcase
            end
            4'd7:
            begin
                case (row_idx)
                    3'd1:    green = 8'b0000_0001;
                    3'd2:    green = 8'b1000_0001;
                    3'd3:    green = 8'b1100_0011;
                    3'd4:    green = 8'b1000_0011;
                    3'd5:    green = 8'b1100_0111;
                    3'd6:    green = 8'b1110_0111;
                    3'd7:    green = 8'b1111_0011;
                    default: green = '0;
                endcase
            end
            4'd9:
            begin
                case (row_idx)
                    3'd2:    green = 8'b0110_0000;
                    3'd3:    green = 8'b1111_1100;
                    3'd4:    green = 8'b0011_1111;
                    3'd5:    green = 8'b0011_1110;
                    3'd6:    green = 8'b0001_1100;
                    default: green = '0;
                endcase
            end
            dz_pkg::PAT_GREEN_ONLY:
            begin
                case (row_idx)
                    3'd2:       green = 8'b0001_1000;
                    3'd3:       green = 8'b0011_1100;
                    3'd4, 3'd5: green = 8'b0111_1110;
                    3'd6:       green = 8'b0010_0100;
                    default:    green = '0;
                endcase
            end
            default:
            begin
                green = '0;  // red-only and unused numbers
            end
        endcase
    end

    // own red bitmaps, fail rule lives in dz_show
    always_comb
    begin
        red = '0;
        case (pat)
            dz_pkg::PAT_RED_A:
            begin
                case (row_idx)
                    3'd1:    red = 8'b0011_1000;
                    3'd2:    red = 8'b0100_0100;
                    3'd3:    red = 8'b0101_1010;
                    3'd4:    red = 8'b0100_1010;
                    3'd5:    red = 8'b0011_0010;
                    3'd6:    red = 8'b1100_0100;
                    3'd7:    red = 8'b0011_1000;
                    default: red = '0;
                endcase
            end
            dz_pkg::PAT_RED_B:
            begin
                case (row_idx)
                    3'd0:    red = 8'b1110_0000;
                    3'd1:    red = 8'b0110_0000;
                    3'd2:    red = 8'b1110_0000;
                    3'd3:    red = 8'b0011_0000;
                    3'd4:    red = 8'b0011_0001;
                    3'd5:    red = 8'b0011_0011;
                    3'd6:    red = 8'b0011_1110;
                    3'd7:    red = 8'b0001_1100;
                    default: red = '0;
                endcase
            end
            default:
            begin
                red = '0;
            end
        endcase
    end

endmodule

//--- src/dz_show.sv
`timescale 1ns/1ps

module dz_show (
    input  logic             clk,
    input  logic             st,
    input  logic             scan_tick,
    input  dz_pkg::pat_t     num,
    input  logic             fail,
    input  dz_pkg::cols_t    green,
    input  dz_pkg::cols_t    red,
    output dz_pkg::row_idx_t row_idx,
    output dz_pkg::pat_t     pat,
    output dz_pkg::rows_t    row,
    output dz_pkg::cols_t    colg,
    output dz_pkg::cols_t    colr
);

    dz_pkg::cols_t red_sel;

    // pattern store looks up the live input, sampled at the strobe below
    assign pat = num;

    // red plane selection
    always_comb
    begin
        case (num)
            dz_pkg::PAT_RED_A, dz_pkg::PAT_RED_B:
            begin
                red_sel = red;  // own bitmap, fail or not
            end
            4'd6, 4'd7, 4'd9:
            begin
                red_sel = green;
            end
            dz_pkg::PAT_GREEN_ONLY:
            begin
                red_sel = '0;
            end
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5:
            begin
                // blobs go dark red on a fail
                red_sel = fail ? '0 : green;
            end
            default:
            begin
                red_sel = '0;
            end
        endcase
    end

    // row counter
    always_ff @(posedge clk or negedge st)
    begin
        if (!st)
            row_idx <= '0;
        else if (scan_tick)
        begin
            if (row_idx == dz_pkg::row_idx_t'(dz_pkg::ROWS - 1))
                row_idx <= '0;
            else
                row_idx <= row_idx + 1'b1;
        end
    end

    // row select and both colour planes update together
    always_ff @(posedge clk or negedge st)
    begin
        if (!st)
        begin
            row  <= '1;  // no row active
            colg <= '0;
            colr <= '0;
        end
        else if (scan_tick)
        begin
            row  <= ~(dz_pkg::rows_t'(1) << row_idx);
            colg <= green;
            colr <= red_sel;
        end
    end

endmodule

//--- src/dz_top.sv
`timescale 1ns/1ps

module dz_top #(
    parameter int SCAN_DIV = 50000  // 1 kHz row rate from 50 MHz
) (
    input  logic          clk,
    input  logic          st,
    input  dz_pkg::pat_t  num,
    input  logic          fail,
    output dz_pkg::rows_t row,
    output dz_pkg::cols_t colg,
    output dz_pkg::cols_t colr
);

    logic             scan_tick;
    dz_pkg::row_idx_t row_idx;
    dz_pkg::pat_t     pat;
    dz_pkg::cols_t    green;
    dz_pkg::cols_t    red;

    tick_gen #(
        .SCAN_DIV (SCAN_DIV)
    ) i_tick_gen (
        .clk       (clk),
        .st        (st),
        .scan_tick (scan_tick)
    );

    dz_show i_dz_show (
        .clk       (clk),
        .st        (st),
        .scan_tick (scan_tick),
        .num       (num),
        .fail      (fail),
        .green     (green),
        .red       (red),
        .row_idx   (row_idx),
        .pat       (pat),
        .row       (row),
        .colg      (colg),
        .colr      (colr)
    );

    pattern_rom i_pattern_rom (
        .pat     (pat),
        .row_idx (row_idx),
        .green   (green),
        .red     (red)
    );

endmodule

//--- bench/dz_model.svh
`ifndef DZ_MODEL_SVH
`define DZ_MODEL_SVH

// whole green frame, row k sits in bits [8k+7:8k]
function automatic logic [63:0] green_frame(input dz_pkg::pat_t p);
    case (p)
        4'd0:    return 64'h0000_183c_3c18_0000;
        4'd1:    return 64'h0000_387c_7c38_0000;
        4'd2:    return 64'h0000_3c7e_7e3c_0000;
        4'd3:    return 64'h003c_7e7e_7e7e_3c00;
        4'd4:    return 64'h3c7e_ffff_ffff_7e3c;
        4'd5:    return 64'hffff_ffff_ffff_ffff;  // full matrix
        4'd6:    return 64'hfbf7_e7c7_e3f1_e3c3;
        4'd7:    return 64'hf3e7_c783_c381_0100;
        4'd9:    return 64'h001c_3e3f_fc60_0000;
        4'd10:   return 64'h0024_7e7e_3c18_0000;
        default: return '0;  // 8, 11 and 12 to 15 are dark green
    endcase
endfunction

// red-only figures
function automatic logic [63:0] own_red_frame(input dz_pkg::pat_t p);
    case (p)
        dz_pkg::PAT_RED_A: return 64'h38c4_324a_5a44_3800;
        dz_pkg::PAT_RED_B: return 64'h1c3e_3331_30e0_60e0;
        default:           return '0;
    endcase
endfunction

function automatic dz_pkg::cols_t green_row(input dz_pkg::pat_t p,
                                            input dz_pkg::row_idx_t k);
    logic [63:0] frame;
    frame = green_frame(p);
    return frame[8 * k +: 8];
endfunction

function automatic dz_pkg::cols_t red_row(input dz_pkg::pat_t p, input logic f,
                                          input dz_pkg::row_idx_t k);
    logic [63:0] frame;
    logic        show_green;
    if (p == dz_pkg::PAT_RED_A || p == dz_pkg::PAT_RED_B)
    begin
        frame = own_red_frame(p);
        return frame[8 * k +: 8];  // same with or without fail
    end
    // patterns that mirror green into red
    if (f)
        show_green = (p == 4'd6 || p == 4'd7 || p == 4'd9);
    else
        show_green = (p <= 4'd7 || p == 4'd9);
    return show_green ? green_row(p, k) : '0;
endfunction

`endif

//--- bench/tb_dz_top.sv
`timescale 1ns/1ps

module tb_dz_top;

    localparam int SCAN_DIV = 4;
    localparam int ROW_WAIT = 20;  // cycles allowed between row changes

    logic          clk;
    logic          st;
    dz_pkg::pat_t  num;
    logic          fail;
    dz_pkg::rows_t row;
    dz_pkg::cols_t colg;
    dz_pkg::cols_t colr;

    int            err_count;
    int            tests_run;
    int            tests_failed;
    bit            hung;
    dz_pkg::rows_t last_row;
    int unsigned   seed_val;

    `include "dz_model.svh"

    dz_top #(
        .SCAN_DIV (SCAN_DIV)
    ) i_dz_top (
        .clk  (clk),
        .st   (st),
        .num  (num),
        .fail (fail),
        .row  (row),
        .colg (colg),
        .colr (colr)
    );

    always #10 clk = ~clk;

    function automatic dz_pkg::rows_t one_cold(input int idx);
        dz_pkg::rows_t r;
        r      = '1;
        r[idx] = 1'b0;
        return r;
    endfunction

    function automatic int cold_index(input dz_pkg::rows_t r);
        int idx;
        idx = -1;
        for (int i = 0; i < dz_pkg::ROWS; i++)
            if (r[i] == 1'b0)
                idx = i;
        return idx;
    endfunction

    task automatic check_rows(input string name, input dz_pkg::rows_t exp,
                              input dz_pkg::rows_t act);
        if (act !== exp)
        begin
            $display("Error %s: expected %b, actual %b", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_cols(input string name, input dz_pkg::cols_t exp,
                              input dz_pkg::cols_t act);
        if (act !== exp)
        begin
            $display("Error %s: expected %b, actual %b", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_one_cold(input string name, output bit ok);
        ok = ($countones(~row) == 1);
        if (!ok)
        begin
            $display("%s: row select %b does not have exactly one active row", name, row);
            err_count++;
        end
    endtask

    task automatic wait_row_change(input string name, output bit seen);
        int n;
        seen = 1'b0;
        if (hung)
            return;
        for (n = 0; n < ROW_WAIT; n++)
        begin
            @(negedge clk);
            if (row !== last_row)
            begin
                last_row = row;
                seen     = 1'b1;
                break;
            end
        end
        if (!seen)
        begin
            $display("%s: row did not change within %0d cycles", name, ROW_WAIT);
            hung = 1'b1;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (hung || err_count != errs_before)
        begin
            tests_failed++;
            $display("test %-10s failed, %0d errors", name, err_count - errs_before);
        end
        else
            $display("test %-10s ok", name);
    endtask

    task automatic test_reset();
        int e0;
        int n;
        bit seen;
        e0 = err_count;
        for (n = 0; n < 5; n++)
        begin
            @(negedge clk);
            check_rows("reset row", '1, row);
            check_cols("reset colg", '0, colg);
            check_cols("reset colr", '0, colr);
        end
        @(posedge clk);
        st <= 1'b1;
        // nothing lit until the first strobe
        seen = 1'b0;
        for (n = 0; n < ROW_WAIT && !seen; n++)
        begin
            @(negedge clk);
            if (row !== '1)
                seen = 1'b1;
            else
            begin
                check_cols("reset idle colg", '0, colg);
                check_cols("reset idle colr", '0, colr);
            end
        end
        last_row = row;
        if (!seen)
        begin
            $display("reset: no row became active after reset release");
            hung = 1'b1;
        end
        else
            check_rows("reset first row", one_cold(0), row);
        finish_test("reset", e0);
    endtask

    task automatic test_scan();
        int e0;
        int n;
        int exp_idx;
        bit seen;
        bit ok;
        e0      = err_count;
        exp_idx = 0;
        for (n = 0; n < 2 * dz_pkg::ROWS + 1 && !hung; n++)
        begin
            wait_row_change("scan", seen);
            if (seen)
            begin
                check_one_cold("scan", ok);
                exp_idx = (exp_idx + 1) % dz_pkg::ROWS;
                check_rows($sformatf("scan step %0d", n), one_cold(exp_idx), row);
            end
        end
        finish_test("scan", e0);
    endtask

    // every pattern once, then random ones, each held for two frames
    task automatic test_patterns(input string name, input logic f, input int n_rand);
        int           e0;
        int           n;
        int           r;
        int           k;
        bit           seen;
        bit           ok;
        dz_pkg::pat_t p;
        e0 = err_count;
        for (n = 0; n < 16 + n_rand && !hung; n++)
        begin
            if (n < 16)
                p = dz_pkg::pat_t'(n);
            else
                p = dz_pkg::pat_t'($urandom % 16);
            @(posedge clk);
            num  <= p;
            fail <= f;
            wait_row_change(name, seen);  // may still show the old inputs
            for (r = 0; r < 2 * dz_pkg::ROWS && seen; r++)
            begin
                wait_row_change(name, seen);
                if (seen)
                begin
                    check_one_cold(name, ok);
                    if (ok)
                    begin
                        k = cold_index(row);
                        check_cols($sformatf("%s colg p%0d r%0d", name, p, k),
                                   green_row(p, dz_pkg::row_idx_t'(k)), colg);
                        check_cols($sformatf("%s colr p%0d r%0d", name, p, k),
                                   red_row(p, f, dz_pkg::row_idx_t'(k)), colr);
                    end
                end
            end
        end
        finish_test(name, e0);
    endtask

    task automatic test_mid_reset();
        int           e0;
        int           n;
        int           exp_idx;
        bit           seen;
        dz_pkg::pat_t p;
        e0 = err_count;
        p  = dz_pkg::pat_t'($urandom % 16);
        @(posedge clk);
        num  <= p;
        fail <= 1'b0;
        for (n = 0; n < 4 && !hung; n++)
            wait_row_change("mid_reset", seen);  // half a frame in
        @(posedge clk);
        st <= 1'b0;
        @(negedge clk);
        check_rows("mid_reset row", '1, row);
        check_cols("mid_reset colg", '0, colg);
        check_cols("mid_reset colr", '0, colr);
        @(posedge clk);
        @(posedge clk);
        st <= 1'b1;
        last_row = '1;
        exp_idx  = 0;
        for (n = 0; n < dz_pkg::ROWS + 1 && !hung; n++)
        begin
            wait_row_change("mid_reset", seen);
            if (seen)
            begin
                check_rows($sformatf("mid_reset step %0d", n), one_cold(exp_idx), row);
                check_cols($sformatf("mid_reset colg r%0d", exp_idx),
                           green_row(p, dz_pkg::row_idx_t'(exp_idx)), colg);
                check_cols($sformatf("mid_reset colr r%0d", exp_idx),
                           red_row(p, 1'b0, dz_pkg::row_idx_t'(exp_idx)), colr);
                exp_idx = (exp_idx + 1) % dz_pkg::ROWS;
            end
        end
        finish_test("mid_reset", e0);
    endtask

    initial
    begin
        clk          = 1'b0;
        st          <= 1'b0;
        num         <= '0;
        fail        <= 1'b0;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        hung         = 1'b0;
        last_row     = '1;
        seed_val     = 32'h2e56;
        void'($urandom(seed_val));

        test_reset();
        test_scan();
        test_patterns("fail0", 1'b0, 20);
        test_patterns("fail1", 1'b1, 20);
        test_mid_reset();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0 && !hung)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+bench
src/dz_pkg.sv
src/tick_gen.sv
src/pattern_rom.sv
src/dz_show.sv
src/dz_top.sv
bench/tb_dz_top.sv

//--- Bender.yml
package:
  name: dz_matrix

sources:
  - src/dz_pkg.sv
  - src/tick_gen.sv
  - src/pattern_rom.sv
  - src/dz_show.sv
  - src/dz_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_dz_top.sv
